// ==== list.f ====
+incdir+dv
src/cgra_conf_pkg.sv
src/cgra_conf_reader_pe.sv
src/cgra_pe_conf_store.sv
src/cgra_conf_readback.sv
src/cgra_conf_top.sv
dv/cgra_conf_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cgra_conf_tb \
  -f list.f -o cgra_conf_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cgra_conf_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== dv/cgra_conf_model.svh ====
`ifndef CGRA_CONF_MODEL_SVH
`define CGRA_CONF_MODEL_SVH

// Shadow state per PE. Set flags mark memory entries written so far.
bit [15:0] m_imem      [NUM_PE][256];
bit        m_imem_set  [NUM_PE][256];
bit [15:0] m_cfile     [NUM_PE][16];
bit        m_cfile_set [NUM_PE][16];
bit [7:0]  m_pc_max    [NUM_PE];
bit [7:0]  m_pc_loop   [NUM_PE];
bit [7:0]  m_ignore    [NUM_PE];
bit [31:0] m_qtd_low   [NUM_PE];
bit [31:0] m_qtd_high  [NUM_PE];
bit [2:0]  m_thread    [NUM_PE];

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s ^ (s << 13);
  x = x ^ (x >> 17);
  return x ^ (x << 5);
endfunction

// Type in 7:0, pe_id in 23:8, thread in 27:24, value in 63:32.
task automatic apply_word(input logic [63:0] w);
  int          p;
  logic [31:0] value;
  p = int'(w[23:8]);
  value = w[63:32];
  if (p < NUM_PE && w[7:0] >= 8'd1 && w[7:0] <= 8'd7) begin
    case (w[7:0])
      cgra_conf_pkg::SET_INSTRUCTION: begin
        m_imem[p][w[35:28]] = w[55:40]; // Address truncated to 8 bits.
        m_imem_set[p][w[35:28]] = 1'b1;
      end
      cgra_conf_pkg::SET_CONST: begin
        m_cfile[p][w[31:28]] = value[15:0];
        m_cfile_set[p][w[31:28]] = 1'b1;
      end
      cgra_conf_pkg::SET_PC_MAX:       m_pc_max[p] = value[7:0];
      cgra_conf_pkg::SET_PC_LOOP:      m_pc_loop[p] = value[7:0];
      cgra_conf_pkg::SET_STORE_IGNORE: m_ignore[p] = value[7:0];
      cgra_conf_pkg::SET_QTD_LOW:      m_qtd_low[p] = value;
      default:                         m_qtd_high[p] = value;
    endcase
    m_thread[p] = w[26:24];
  end
endtask

function automatic logic [31:0] expected_read(input int p, input logic [2:0] field,
                                              input logic [7:0] addr);
  logic [31:0] r;
  r = '0;
  case (field)
    cgra_conf_pkg::RD_INSTR:    r[15:0] = m_imem[p][addr];
    cgra_conf_pkg::RD_CONST:    r[15:0] = m_cfile[p][addr[3:0]];
    cgra_conf_pkg::RD_PC_MAX:   r[7:0] = m_pc_max[p];
    cgra_conf_pkg::RD_PC_LOOP:  r[7:0] = m_pc_loop[p];
    cgra_conf_pkg::RD_IGNORE:   r[7:0] = m_ignore[p];
    cgra_conf_pkg::RD_QTD_LOW:  r = m_qtd_low[p];
    cgra_conf_pkg::RD_QTD_HIGH: r = m_qtd_high[p];
    default:                    r[2:0] = m_thread[p];
  endcase
  return r;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected) begin
    $display("FAILED %s expected %h actual %h", name, expected, actual);
    error_count++;
    stop_on_error();
  end
endtask

`endif

// ==== dv/cgra_conf_tb.sv ====
`timescale 1ns/100ps

module cgra_conf_tb;

  localparam int NUM_PE     = 4;
  localparam int ROUNDS     = 8;
  localparam int BURST_LEN  = 60;
  localparam int IDLE_LEN   = 3;
  localparam int WAIT_LIMIT = 20;

  logic        clk;
  logic        rst;
  logic [63:0] conf_bus;
  logic [1:0]  rd_pe;
  logic [2:0]  rd_field;
  logic [7:0]  rd_addr;
  logic [31:0] rd_data;

  logic [31:0] rng_state;
  int          error_count;
  bit          read_pending;
  logic [31:0] read_expected;

  `include "cgra_conf_model.svh"

  cgra_conf_top #(
    .NUM_PE(NUM_PE)
  ) u_dut (
    .clk(clk),
    .rst(rst),
    .conf_bus(conf_bus),
    .rd_pe(rd_pe),
    .rd_field(rd_field),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic wait_readback_clear();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (rd_data !== '0 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (rd_data !== '0) begin
      $display("Timeout: readback data did not clear to zero after reset.");
      stop_on_error();
    end
  endtask

  // The previous request's result is checked while this one is issued.
  task automatic issue_read(input int p, input logic [2:0] field, input logic [7:0] addr);
    @(posedge clk);
    rd_pe    <= 2'(p);
    rd_field <= field;
    rd_addr  <= addr;
    @(negedge clk);
    if (read_pending) check_value("rd_data", read_expected, rd_data);
    read_pending  = 1'b1;
    read_expected = expected_read(p, field, addr);
  endtask

  task automatic flush_read();
    @(posedge clk);
    @(negedge clk);
    if (read_pending) check_value("rd_data", read_expected, rd_data);
    read_pending = 1'b0;
  endtask

  task automatic sweep_readback();
    logic [31:0] r;
    for (int p = 0; p < NUM_PE; p++) begin
      r = next_random();
      issue_read(p, cgra_conf_pkg::RD_PC_MAX, r[7:0]);
      issue_read(p, cgra_conf_pkg::RD_PC_LOOP, r[15:8]);
      issue_read(p, cgra_conf_pkg::RD_IGNORE, r[23:16]);
      issue_read(p, cgra_conf_pkg::RD_QTD_LOW, r[31:24]);
      issue_read(p, cgra_conf_pkg::RD_QTD_HIGH, r[7:0]);
      issue_read(p, cgra_conf_pkg::RD_THREAD, r[15:8]);
      for (int c = 0; c < 16; c++) begin
        r = next_random();
        if (m_cfile_set[p][c]) issue_read(p, cgra_conf_pkg::RD_CONST, {r[3:0], 4'(c)});
      end
      for (int a = 0; a < 256; a++) begin
        if (m_imem_set[p][a]) issue_read(p, cgra_conf_pkg::RD_INSTR, 8'(a));
      end
    end
    flush_read();
  endtask

  // Types 8 and 9 and PE ids 4 and 5 reach no store.
  task automatic send_burst();
    logic [63:0] w;
    logic [31:0] r;
    for (int i = 0; i < BURST_LEN; i++) begin
      w[63:32] = next_random();
      w[31:0]  = next_random();
      r = next_random();
      w[7:0]  = 8'(r % 10);
      w[23:8] = 16'((r >> 8) % 6);
      @(posedge clk);
      conf_bus <= w;
      apply_word(w);
    end
    for (int i = 0; i < IDLE_LEN; i++) begin
      @(posedge clk);
      conf_bus <= '0;
    end
  endtask

  // Each write is read back at the first edge that must already see it.
  task automatic write_then_read();
    logic [63:0] w;
    logic [31:0] r;
    int          p;
    for (int i = 0; i < NUM_PE; i++) begin
      w[63:32] = next_random();
      w[31:0]  = next_random();
      r = next_random();
      p = int'(r[7:0]) % NUM_PE;
      w[7:0]  = 8'(1 + r[15:8] % 7);
      w[23:8] = 16'(p);
      @(posedge clk);
      conf_bus <= w;
      apply_word(w);
      @(posedge clk);
      conf_bus <= '0;
      if (r[16]) begin
        issue_read(p, cgra_conf_pkg::RD_THREAD, r[31:24]);
      end else begin
        case (w[7:0])
          cgra_conf_pkg::SET_INSTRUCTION: begin
            issue_read(p, cgra_conf_pkg::RD_INSTR, w[35:28]);
          end
          cgra_conf_pkg::SET_CONST: begin
            issue_read(p, cgra_conf_pkg::RD_CONST, {r[23:20], w[31:28]});
          end
          default: begin
            issue_read(p, 3'(w[7:0] - 8'd1), r[31:24]); // Types 3 to 7 map to fields 2 to 6.
          end
        endcase
      end
      flush_read();
    end
  endtask

  initial begin
    rst      <= 1'b1;
    conf_bus <= '0;
    rd_pe    <= '0;
    rd_field <= cgra_conf_pkg::RD_THREAD;
    rd_addr  <= '0;
    rng_state    = 32'hea72;
    error_count  = 0;
    read_pending = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    wait_readback_clear();
    sweep_readback(); // Reset values only.
    for (int round = 0; round < ROUNDS; round++) begin
      send_burst();
      sweep_readback();
      write_then_read();
    end
    if (error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_on_error();
    end
  end

endmodule

// ==== src/cgra_conf_top.sv ====
`timescale 1ns/100ps

module cgra_conf_top #(
  parameter int NUM_PE = 4
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [63:0]                           conf_bus,
  input  logic [$clog2(NUM_PE)-1:0]             rd_pe,
  input  logic [2:0]                            rd_field,
  input  logic [cgra_conf_pkg::INST_ADDR_W-1:0] rd_addr,
  output logic [cgra_conf_pkg::RD_W-1:0]        rd_data
);

  logic [NUM_PE*cgra_conf_pkg::RD_W-1:0] pe_rd_bus;

  for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
    logic                                   instruction_we;
    logic [cgra_conf_pkg::INST_ADDR_W-1:0]  instruction_addr;
    logic [cgra_conf_pkg::INST_W-1:0]       instruction_data;
    logic                                   const_we;
    logic [cgra_conf_pkg::CONST_ADDR_W-1:0] const_waddr;
    logic [cgra_conf_pkg::CONST_W-1:0]      const_data;
    logic                                   pc_max_we;
    logic [cgra_conf_pkg::PC_W-1:0]         pc_max;
    logic                                   pc_loop_we;
    logic [cgra_conf_pkg::PC_W-1:0]         pc_loop;
    logic                                   ignore_we;
    logic [cgra_conf_pkg::PC_W-1:0]         ignore_data;
    logic                                   qtd_we_low;
    logic [31:0]                            qtd_low;
    logic                                   qtd_we_high;
    logic [31:0]                            qtd_high;
    logic [cgra_conf_pkg::THREAD_W-1:0]     thread_id;

    cgra_conf_reader_pe #(
      .PE_ID(i)
    ) u_reader (
      .clk(clk), .rst(rst), .conf_bus(conf_bus),
      .instruction_we(instruction_we), .instruction_addr(instruction_addr),
      .instruction_data(instruction_data),
      .const_we(const_we), .const_waddr(const_waddr), .const_data(const_data),
      .pc_max_we(pc_max_we), .pc_max(pc_max),
      .pc_loop_we(pc_loop_we), .pc_loop(pc_loop),
      .ignore_we(ignore_we), .ignore_data(ignore_data),
      .qtd_we_low(qtd_we_low), .qtd_low(qtd_low),
      .qtd_we_high(qtd_we_high), .qtd_high(qtd_high),
      .thread_id(thread_id)
    );

    cgra_pe_conf_store u_store (
      .clk(clk), .rst(rst),
      .instruction_we(instruction_we), .instruction_addr(instruction_addr),
      .instruction_data(instruction_data),
      .const_we(const_we), .const_waddr(const_waddr), .const_data(const_data),
      .pc_max_we(pc_max_we), .pc_max(pc_max),
      .pc_loop_we(pc_loop_we), .pc_loop(pc_loop),
      .ignore_we(ignore_we), .ignore_data(ignore_data),
      .qtd_we_low(qtd_we_low), .qtd_low(qtd_low),
      .qtd_we_high(qtd_we_high), .qtd_high(qtd_high),
      .thread_id(thread_id),
      .rd_field(rd_field), .rd_addr(rd_addr),
      .pe_rd_data(pe_rd_bus[i*cgra_conf_pkg::RD_W +: cgra_conf_pkg::RD_W])
    );
  end

  cgra_conf_readback #(
    .NUM_PE(NUM_PE)
  ) u_readback (
    .clk(clk),
    .rst(rst),
    .rd_pe(rd_pe),
    .pe_rd_bus(pe_rd_bus),
    .rd_data(rd_data)
  );

endmodule

// ==== src/cgra_conf_readback.sv ====
`timescale 1ns/100ps

module cgra_conf_readback #(
  parameter int NUM_PE = 4
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [$clog2(NUM_PE)-1:0]             rd_pe,
  input  logic [NUM_PE*cgra_conf_pkg::RD_W-1:0] pe_rd_bus,
  output logic [cgra_conf_pkg::RD_W-1:0]        rd_data
);

  logic [cgra_conf_pkg::RD_W-1:0] sel_word;

  assign sel_word = pe_rd_bus[rd_pe*cgra_conf_pkg::RD_W +: cgra_conf_pkg::RD_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data <= '0;
    end else begin
      rd_data <= sel_word; // One cycle of read latency.
    end
  end

endmodule

// ==== src/cgra_pe_conf_store.sv ====
`timescale 1ns/100ps

module cgra_pe_conf_store (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   instruction_we,
  input  logic [cgra_conf_pkg::INST_ADDR_W-1:0]  instruction_addr,
  input  logic [cgra_conf_pkg::INST_W-1:0]       instruction_data,
  input  logic                                   const_we,
  input  logic [cgra_conf_pkg::CONST_ADDR_W-1:0] const_waddr,
  input  logic [cgra_conf_pkg::CONST_W-1:0]      const_data,
  input  logic                                   pc_max_we,
  input  logic [cgra_conf_pkg::PC_W-1:0]         pc_max,
  input  logic                                   pc_loop_we,
  input  logic [cgra_conf_pkg::PC_W-1:0]         pc_loop,
  input  logic                                   ignore_we,
  input  logic [cgra_conf_pkg::PC_W-1:0]         ignore_data,
  input  logic                                   qtd_we_low,
  input  logic [31:0]                            qtd_low,
  input  logic                                   qtd_we_high,
  input  logic [31:0]                            qtd_high,
  input  logic [cgra_conf_pkg::THREAD_W-1:0]     thread_id,
  input  logic [2:0]                             rd_field,
  input  logic [cgra_conf_pkg::INST_ADDR_W-1:0]  rd_addr,
  output logic [cgra_conf_pkg::RD_W-1:0]         pe_rd_data
);

  logic [cgra_conf_pkg::INST_W-1:0]   imem [0:(1 << cgra_conf_pkg::INST_ADDR_W)-1];
  logic [cgra_conf_pkg::CONST_W-1:0]  cfile [0:(1 << cgra_conf_pkg::CONST_ADDR_W)-1];
  logic [cgra_conf_pkg::PC_W-1:0]     pc_max_q;
  logic [cgra_conf_pkg::PC_W-1:0]     pc_loop_q;
  logic [cgra_conf_pkg::PC_W-1:0]     ignore_q;
  logic [31:0]                        qtd_low_q;
  logic [31:0]                        qtd_high_q;
  logic [cgra_conf_pkg::THREAD_W-1:0] thread_q;
  logic [cgra_conf_pkg::CONST_ADDR_W-1:0] const_raddr;
  logic                               any_we;

  assign any_we = instruction_we | const_we | pc_max_we | pc_loop_we |
                  ignore_we | qtd_we_low | qtd_we_high;
  assign const_raddr = rd_addr[cgra_conf_pkg::CONST_ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (instruction_we) imem[instruction_addr] <= instruction_data;
    if (const_we) cfile[const_waddr] <= const_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_max_q   <= '0;
      pc_loop_q  <= '0;
      ignore_q   <= '0;
      qtd_low_q  <= '0;
      qtd_high_q <= '0;
      thread_q   <= '0;
    end else begin
      if (pc_max_we) pc_max_q <= pc_max;
      if (pc_loop_we) pc_loop_q <= pc_loop;
      if (ignore_we) ignore_q <= ignore_data;
      if (qtd_we_low) qtd_low_q <= qtd_low;
      if (qtd_we_high) qtd_high_q <= qtd_high;
      if (any_we) thread_q <= thread_id; // Last accepted write.
    end
  end

  // A write in flight is forwarded so a read in the same cycle sees it.
  always_comb begin
    pe_rd_data = '0;
    case (rd_field)
      cgra_conf_pkg::RD_INSTR: begin
        if (instruction_we && instruction_addr == rd_addr)
          pe_rd_data[cgra_conf_pkg::INST_W-1:0] = instruction_data;
        else
          pe_rd_data[cgra_conf_pkg::INST_W-1:0] = imem[rd_addr];
      end
      cgra_conf_pkg::RD_CONST: begin
        if (const_we && const_waddr == const_raddr)
          pe_rd_data[cgra_conf_pkg::CONST_W-1:0] = const_data;
        else
          pe_rd_data[cgra_conf_pkg::CONST_W-1:0] = cfile[const_raddr];
      end
      cgra_conf_pkg::RD_PC_MAX:
        pe_rd_data[cgra_conf_pkg::PC_W-1:0] = pc_max_we ? pc_max : pc_max_q;
      cgra_conf_pkg::RD_PC_LOOP:
        pe_rd_data[cgra_conf_pkg::PC_W-1:0] = pc_loop_we ? pc_loop : pc_loop_q;
      cgra_conf_pkg::RD_IGNORE:
        pe_rd_data[cgra_conf_pkg::PC_W-1:0] = ignore_we ? ignore_data : ignore_q;
      cgra_conf_pkg::RD_QTD_LOW:
        pe_rd_data = qtd_we_low ? qtd_low : qtd_low_q;
      cgra_conf_pkg::RD_QTD_HIGH:
        pe_rd_data = qtd_we_high ? qtd_high : qtd_high_q;
      default:
        pe_rd_data[cgra_conf_pkg::THREAD_W-1:0] = any_we ? thread_id : thread_q;
    endcase
  end

endmodule

// ==== src/cgra_conf_reader_pe.sv ====
`timescale 1ns/100ps

module cgra_conf_reader_pe #(
  parameter logic [cgra_conf_pkg::PE_ID_W-1:0] PE_ID = '0
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [63:0]                            conf_bus,
  output logic                                   instruction_we,
  output logic [cgra_conf_pkg::INST_ADDR_W-1:0]  instruction_addr,
  output logic [cgra_conf_pkg::INST_W-1:0]       instruction_data,
  output logic                                   const_we,
  output logic [cgra_conf_pkg::CONST_ADDR_W-1:0] const_waddr,
  output logic [cgra_conf_pkg::CONST_W-1:0]      const_data,
  output logic                                   pc_max_we,
  output logic [cgra_conf_pkg::PC_W-1:0]         pc_max,
  output logic                                   pc_loop_we,
  output logic [cgra_conf_pkg::PC_W-1:0]         pc_loop,
  output logic                                   ignore_we,
  output logic [cgra_conf_pkg::PC_W-1:0]         ignore_data,
  output logic                                   qtd_we_low,
  output logic [31:0]                            qtd_low,
  output logic                                   qtd_we_high,
  output logic [31:0]                            qtd_high,
  output logic [cgra_conf_pkg::THREAD_W-1:0]     thread_id
);

  cgra_conf_pkg::conf_word_t word_q;
  logic                      id_match;

  always_ff @(posedge clk) begin
    if (rst) begin
      word_q <= '0;
    end else begin
      word_q <= conf_bus; // Stage 1.
    end
  end

  assign id_match = (word_q.inst.pe_id == PE_ID);

  always_ff @(posedge clk) begin
    if (rst) begin
      instruction_we <= 1'b0;
      const_we       <= 1'b0;
      pc_max_we      <= 1'b0;
      pc_loop_we     <= 1'b0;
      ignore_we      <= 1'b0;
      qtd_we_low     <= 1'b0;
      qtd_we_high    <= 1'b0;
    end else begin
      instruction_we <= 1'b0;
      const_we       <= 1'b0;
      pc_max_we      <= 1'b0;
      pc_loop_we     <= 1'b0;
      ignore_we      <= 1'b0;
      qtd_we_low     <= 1'b0;
      qtd_we_high    <= 1'b0;
      if (id_match) begin
        case (word_q.inst.conf_type)
          cgra_conf_pkg::SET_INSTRUCTION:  instruction_we <= 1'b1;
          cgra_conf_pkg::SET_CONST:        const_we <= 1'b1;
          cgra_conf_pkg::SET_PC_MAX:       pc_max_we <= 1'b1;
          cgra_conf_pkg::SET_PC_LOOP:      pc_loop_we <= 1'b1;
          cgra_conf_pkg::SET_STORE_IGNORE: ignore_we <= 1'b1;
          cgra_conf_pkg::SET_QTD_LOW:      qtd_we_low <= 1'b1;
          cgra_conf_pkg::SET_QTD_HIGH:     qtd_we_high <= 1'b1;
          default: ; // NOT_CONF and unknown codes.
        endcase
      end
    end
  end

  // Payload follows the enables, truncated to the store widths.
  always_ff @(posedge clk) begin
    instruction_addr <= word_q.inst.inst_addr[cgra_conf_pkg::INST_ADDR_W-1:0];
    instruction_data <= word_q.inst.instruction;
    const_waddr      <= word_q.data.const_addr;
    const_data       <= word_q.data.value[cgra_conf_pkg::CONST_W-1:0];
    pc_max           <= word_q.data.value[cgra_conf_pkg::PC_W-1:0];
    pc_loop          <= word_q.data.value[cgra_conf_pkg::PC_W-1:0];
    ignore_data      <= word_q.data.value[cgra_conf_pkg::PC_W-1:0];
    qtd_low          <= word_q.data.value;
    qtd_high         <= word_q.data.value;
    thread_id        <= word_q.inst.thread[cgra_conf_pkg::THREAD_W-1:0];
  end

endmodule

// ==== src/cgra_conf_pkg.sv ====
package cgra_conf_pkg;

  localparam int INST_ADDR_W  = 8;
  localparam int INST_W       = 16;
  localparam int CONST_ADDR_W = 4;
  localparam int CONST_W      = 16;
  localparam int PC_W         = 8;
  localparam int THREAD_W     = 3;
  localparam int RD_W         = 32;
  localparam int PE_ID_W      = 16;

  // Configuration word types.
  localparam logic [7:0] NOT_CONF         = 8'd0;
  localparam logic [7:0] SET_INSTRUCTION  = 8'd1;
  localparam logic [7:0] SET_CONST        = 8'd2;
  localparam logic [7:0] SET_PC_MAX       = 8'd3;
  localparam logic [7:0] SET_PC_LOOP      = 8'd4;
  localparam logic [7:0] SET_STORE_IGNORE = 8'd5;
  localparam logic [7:0] SET_QTD_LOW      = 8'd6;
  localparam logic [7:0] SET_QTD_HIGH     = 8'd7;

  // Readback field select.
  localparam logic [2:0] RD_INSTR    = 3'd0;
  localparam logic [2:0] RD_CONST    = 3'd1;
  localparam logic [2:0] RD_PC_MAX   = 3'd2;
  localparam logic [2:0] RD_PC_LOOP  = 3'd3;
  localparam logic [2:0] RD_IGNORE   = 3'd4;
  localparam logic [2:0] RD_QTD_LOW  = 3'd5;
  localparam logic [2:0] RD_QTD_HIGH = 3'd6;
  localparam logic [2:0] RD_THREAD   = 3'd7;

  // One bus word, seen as an instruction write or as a data write.
  typedef union packed {
    struct packed {
      logic [7:0]  pad;
      logic [15:0] instruction;
      logic [11:0] inst_addr;
      logic [3:0]  thread;
      logic [15:0] pe_id;
      logic [7:0]  conf_type;
    } inst;
    struct packed {
      logic [31:0] value;
      logic [3:0]  const_addr;
      logic [3:0]  thread;
      logic [15:0] pe_id;
      logic [7:0]  conf_type;
    } data;
  } conf_word_t;

endpackage
